// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef logic [31:0] insn_t;

    localparam int GPR_W      = 5;
    localparam int SP_INDEX   = 31;
    localparam int INSN_BYTES = 4;

    // ############################################################
    // Field positions inside an A64 word
    // ############################################################

    localparam int RD_LO    = 0;   // Destination register
    localparam int RN_LO    = 5;   // First source register
    localparam int RM_LO    = 16;  // Second source register
    localparam int IMM12_LO = 10;
    localparam int IMM12_W  = 12;
    localparam int IMM16_LO = 5;
    localparam int IMM16_W  = 16;
    localparam int HW_LO    = 21;  // Halfword shift of the move-wide forms
    localparam int HW_W     = 2;

    // ############################################################
    // Opcode prefixes, 64-bit variants, matched from bit 31 down
    // ############################################################

    localparam logic [9:0] ADD_IMM = 10'b1001000100;
    localparam logic [9:0] SUB_IMM = 10'b1101000100;

    // Shifted-register forms with LSL #0 only
    localparam logic [10:0] ADDS_REG = 11'b10101011000;
    localparam logic [10:0] SUBS_REG = 11'b11101011000;
    localparam logic [10:0] ORR_REG  = 11'b10101010000;
    localparam logic [10:0] EOR_REG  = 11'b11001010000;
    localparam logic [10:0] ANDS_REG = 11'b11101010000;
    localparam logic [10:0] HLT      = 11'b11010100010;

    localparam logic [8:0] MOVZ = 9'b110100101;
    localparam logic [8:0] MOVK = 9'b111100101;

    localparam logic [5:0] B     = 6'b000101;
    localparam logic [7:0] BCOND = 8'b01010100;

    localparam insn_t NOP_WORD = 32'hd503201f;

endpackage

`default_nettype wire

// ==== uop_pkg.sv ====
`default_nettype none

package uop_pkg;

    localparam int DECODE_WIDTH_DEFAULT = 2;
    localparam int PC_W                 = 64;
    localparam int IMM_W                = 16;

    typedef enum logic [3:0] {
        UOP_NOP,
        UOP_ADD,
        UOP_SUB,
        UOP_ORR,
        UOP_EOR,
        UOP_AND,
        UOP_MOVZ,
        UOP_MOVK,
        UOP_BCOND,
        UOP_HLT
    } uop_code_t;

    typedef struct packed {
        logic [isa_pkg::GPR_W-1:0] gpr;
        logic                      is_sp;  // Index 31 names SP rather than XZR
    } reg_spec_t;

    // ############################################################
    // Operand word, read as register-register or register-immediate
    // ############################################################

    typedef struct packed {
        reg_spec_t          dst;
        reg_spec_t          src;
        logic [IMM_W-1:0]   imm;
        logic [1:0]         hw;
        logic               set_nzcv;
    } ri_ops_t;

    localparam int RR_PAD_W = $bits(ri_ops_t) - 3 * $bits(reg_spec_t);

    typedef struct packed {
        reg_spec_t             dst;
        reg_spec_t             src1;
        reg_spec_t             src2;
        logic [RR_PAD_W-1:0]   pad;
    } rr_ops_t;

    typedef union packed {
        rr_ops_t rr;
        ri_ops_t ri;
    } operands_t;

    typedef struct packed {
        uop_code_t         code;
        logic              use_rr;  // Selects the rr view of ops
        logic [PC_W-1:0]   pc;
        operands_t         ops;
    } uop_t;

    typedef struct packed {
        logic [DECODE_WIDTH_DEFAULT-1:0] valid;
        uop_t [DECODE_WIDTH_DEFAULT-1:0] slot;
    } uop_group_t;

    typedef struct packed {
        isa_pkg::insn_t [DECODE_WIDTH_DEFAULT-1:0] insn;
        logic [PC_W-1:0]                           pc;     // Address of lane 0
        logic [DECODE_WIDTH_DEFAULT-1:0]           taken;  // Predict-taken hint per lane
    } fetch_group_t;

endpackage

`default_nettype wire

// ==== insn_decoder.sv ====
`default_nettype none

module insn_decoder (
    input  isa_pkg::insn_t                insn,
    input  logic [uop_pkg::PC_W-1:0]      pc,
    input  logic                          taken,
    output uop_pkg::uop_t                 uop,
    output logic                          emit,
    output logic                          stop
);
    import isa_pkg::*;
    import uop_pkg::*;

    logic [GPR_W-1:0] rd;
    logic [GPR_W-1:0] rn;
    logic [GPR_W-1:0] rm;
    logic             rn_is_31;
    logic             is_rr;
    uop_code_t        rr_code;

    assign rd       = insn[RD_LO +: GPR_W];
    assign rn       = insn[RN_LO +: GPR_W];
    assign rm       = insn[RM_LO +: GPR_W];
    assign rn_is_31 = (rn == GPR_W'(SP_INDEX));

    // ############################################################
    // Register-register ALU forms
    // ############################################################

    always_comb begin
        is_rr   = 1'b1;
        rr_code = UOP_NOP;
        case (insn[31 -: $bits(ADDS_REG)])
            ADDS_REG: rr_code = UOP_ADD;
            SUBS_REG: rr_code = UOP_SUB;
            ORR_REG:  rr_code = UOP_ORR;
            EOR_REG:  rr_code = UOP_EOR;
            ANDS_REG: rr_code = UOP_AND;
            default:  is_rr = 1'b0;
        endcase
    end

    // ############################################################
    // Micro-op build
    // ############################################################

    always_comb begin
        uop    = '0;
        uop.pc = pc;
        emit   = 1'b0;
        stop   = 1'b0;

        if (is_rr) begin
            uop.code              = rr_code;
            uop.use_rr            = 1'b1;
            uop.ops.rr.dst.gpr    = rd;
            uop.ops.rr.src1.gpr   = rn;
            uop.ops.rr.src2.gpr   = rm;
            emit                  = 1'b1;
        end else if (insn[31 -: $bits(ADD_IMM)] == ADD_IMM ||
                     insn[31 -: $bits(SUB_IMM)] == SUB_IMM) begin
            uop.code = (insn[31 -: $bits(SUB_IMM)] == SUB_IMM) ? UOP_SUB : UOP_ADD;
            uop.ops.ri.dst.gpr   = rd;
            uop.ops.ri.dst.is_sp = rn_is_31 && (rd == GPR_W'(SP_INDEX));  // Only SP-to-SP moves
            uop.ops.ri.src.gpr   = rn;
            uop.ops.ri.src.is_sp = rn_is_31;
            uop.ops.ri.imm       = IMM_W'(insn[IMM12_LO +: IMM12_W]);
            emit                 = 1'b1;
        end else if (insn[31 -: $bits(MOVZ)] == MOVZ ||
                     insn[31 -: $bits(MOVK)] == MOVK) begin
            uop.code = (insn[31 -: $bits(MOVK)] == MOVK) ? UOP_MOVK : UOP_MOVZ;
            uop.ops.ri.dst.gpr = rd;
            uop.ops.ri.imm     = insn[IMM16_LO +: IMM16_W];
            uop.ops.ri.hw      = insn[HW_LO +: HW_W];
            emit               = 1'b1;
        end else if (insn[31 -: $bits(HLT)] == HLT) begin
            uop.code = UOP_HLT;
            emit     = 1'b1;
        end else if (insn[31 -: $bits(BCOND)] == BCOND) begin
            uop.code = UOP_BCOND;
            emit     = 1'b1;
            stop     = taken;  // Fetch redirects, later lanes are off-path
        end else if (insn[31 -: $bits(B)] == B) begin
            stop = 1'b1;  // Resolved at fetch, nothing left to execute
        end
    end

endmodule

`default_nettype wire

// ==== group_packer.sv ====
`default_nettype none

module group_packer #(
    parameter int DECODE_WIDTH = uop_pkg::DECODE_WIDTH_DEFAULT
) (
    input  uop_pkg::fetch_group_t fetch,
    output uop_pkg::uop_group_t   group
);
    import isa_pkg::*;
    import uop_pkg::*;

    uop_t [DECODE_WIDTH-1:0] lane_uop;
    logic [DECODE_WIDTH-1:0] lane_emit;
    logic [DECODE_WIDTH-1:0] lane_stop;
    logic [PC_W-1:0]         lane_pc [DECODE_WIDTH];

    // ############################################################
    // One decoder per lane
    // ############################################################

    for (genvar lane = 0; lane < DECODE_WIDTH; lane++) begin : g_lane
        assign lane_pc[lane] = fetch.pc + PC_W'(INSN_BYTES * lane);

        insn_decoder u_dec (
            .insn  (fetch.insn[lane]),
            .pc    (lane_pc[lane]),
            .taken (fetch.taken[lane]),
            .uop   (lane_uop[lane]),
            .emit  (lane_emit[lane]),
            .stop  (lane_stop[lane])
        );
    end

    // ############################################################
    // Truncation and compaction into the low slots
    // ############################################################

    always_comb begin
        int   fill;
        logic stopped;

        group   = '0;
        fill    = 0;
        stopped = 1'b0;
        for (int lane = 0; lane < DECODE_WIDTH; lane++) begin
            if (!stopped && lane_emit[lane]) begin
                group.valid[fill] = 1'b1;
                group.slot[fill]  = lane_uop[lane];
                fill++;
            end
            stopped = stopped | lane_stop[lane];  // A stopping lane still emits itself
        end
    end

endmodule

`default_nettype wire

// ==== decode_skid.sv ====
`default_nettype none

module decode_skid #(
    parameter int DECODE_WIDTH = uop_pkg::DECODE_WIDTH_DEFAULT
) (
    input  logic                clk_in,
    input  logic                rst,
    input  logic                flush,
    input  uop_pkg::uop_group_t in,
    input  logic                in_valid,
    input  logic                exe_ready,
    output logic                in_ready,
    output uop_pkg::uop_group_t out,
    output logic                out_valid
);
    import uop_pkg::*;

    logic                    out_valid_q;
    logic [DECODE_WIDTH-1:0] out_mask_q;
    uop_t [DECODE_WIDTH-1:0] out_slot_q;
    uop_group_t              skid_q;
    logic                    skid_full_q;
    logic                    in_ready_q;

    logic out_free;
    logic accept;
    logic load_from_skid;
    logic load_from_in;
    logic fill_skid;
    logic skid_full_d;

    // ############################################################
    // Transfer decisions
    // ############################################################

    always_comb begin
        out_free       = !out_valid_q || exe_ready;  // Output empty or leaving this edge
        accept         = in_valid && in_ready_q;
        load_from_skid = out_free && skid_full_q;
        load_from_in   = out_free && !skid_full_q && accept;
        fill_skid      = !out_free && accept;
        skid_full_d    = skid_full_q ? !out_free : fill_skid;
    end

    always_ff @(posedge clk_in) begin
        if (rst || flush) begin
            out_valid_q <= 1'b0;
            out_mask_q  <= '0;
            skid_full_q <= 1'b0;
            in_ready_q  <= 1'b0;
        end else begin
            skid_full_q <= skid_full_d;
            in_ready_q  <= !skid_full_d;
            if (load_from_skid) begin
                out_valid_q <= 1'b1;
                out_mask_q  <= skid_q.valid;
            end else if (load_from_in) begin
                out_valid_q <= 1'b1;
                out_mask_q  <= in.valid;
            end else if (out_free) begin
                out_valid_q <= 1'b0;
                out_mask_q  <= '0;
            end
        end
    end

    // Payload follows the control decisions above
    always_ff @(posedge clk_in) begin
        if (load_from_skid) begin
            out_slot_q <= skid_q.slot;
        end else if (load_from_in) begin
            out_slot_q <= in.slot;
        end
        if (fill_skid) begin
            skid_q <= in;
        end
    end

    assign out       = '{valid: out_mask_q, slot: out_slot_q};
    assign out_valid = out_valid_q;
    assign in_ready  = in_ready_q;

endmodule

`default_nettype wire

// ==== decode_top.sv ====
`default_nettype none

module decode_top #(
    parameter int DECODE_WIDTH = uop_pkg::DECODE_WIDTH_DEFAULT
) (
    input  logic                  clk_in,
    input  logic                  rst,
    input  logic                  flush,
    input  uop_pkg::fetch_group_t fetch,
    input  logic                  fetch_valid,
    output logic                  decode_ready,
    output uop_pkg::uop_group_t   out,
    output logic                  out_valid,
    input  logic                  exe_ready
);
    import uop_pkg::*;

    uop_group_t packed_group;
    logic       packed_valid;

    if (DECODE_WIDTH != DECODE_WIDTH_DEFAULT) begin : g_width_check
        $error("DECODE_WIDTH must equal the group width of the uop_pkg types");
    end

    group_packer #(
        .DECODE_WIDTH (DECODE_WIDTH)
    ) u_packer (
        .fetch (fetch),
        .group (packed_group)
    );

    assign packed_valid = fetch_valid && (|packed_group.valid);  // Empty groups are dropped here

    decode_skid #(
        .DECODE_WIDTH (DECODE_WIDTH)
    ) u_skid (
        .clk_in    (clk_in),
        .rst       (rst),
        .flush     (flush),
        .in        (packed_group),
        .in_valid  (packed_valid),
        .exe_ready (exe_ready),
        .in_ready  (decode_ready),
        .out       (out),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

// ==== decode_chk.sv ====
`default_nettype none

module decode_chk (
    input logic                clk_in,
    input logic                rst,
    input logic                flush,
    input uop_pkg::uop_group_t out,
    input logic                out_valid,
    input logic                exe_ready
);
    import uop_pkg::*;

    localparam int W = DECODE_WIDTH_DEFAULT;

    logic [W-1:0] valid_plus_one;

    assign valid_plus_one = out.valid + W'(1);  // Zero when ANDed with a low-packed mask

    // ############################################################
    // Handshake and packing properties
    // ############################################################

    a_hold: assert property (@(posedge clk_in) disable iff (rst || flush)
        out_valid && !exe_ready && !flush |=> out_valid && $stable(out))
        else $error("Output group changed while execute was stalling");

    a_packed: assert property (@(posedge clk_in) disable iff (rst)
        out_valid |-> (out.valid != '0) && ((out.valid & valid_plus_one) == '0))
        else $error("Output slots are not packed from slot 0");

    a_clear: assert property (@(posedge clk_in) rst || flush |=> !out_valid)
        else $error("Output still valid after reset or flush");

endmodule

bind decode_top decode_chk chk (
    .clk_in    (clk_in),
    .rst       (rst),
    .flush     (flush),
    .out       (out),
    .out_valid (out_valid),
    .exe_ready (exe_ready)
);

`default_nettype wire

// ==== decode_tb.sv ====
`default_nettype none

module decode_tb;
    import isa_pkg::*;
    import uop_pkg::*;

    localparam int W       = DECODE_WIDTH_DEFAULT;
    localparam int TIMEOUT = 200;  // Longest single wait in cycles

    logic         clk_in      = 1'b0;
    logic         rst         = 1'b1;
    logic         flush       = 1'b0;
    fetch_group_t fetch       = '0;
    logic         fetch_valid = 1'b0;
    logic         exe_ready   = 1'b0;
    logic         decode_ready;
    uop_group_t   out;
    logic         out_valid;

    logic         rand_ready = 1'b0;  // Random back-pressure from execute
    logic         prev_stall = 1'b0;
    uop_group_t   prev_out;
    uop_group_t   expect_q[$];
    int           errors   = 0;
    int           checks   = 0;
    int           timeouts = 0;

    always #20 clk_in = ~clk_in;

    decode_top #(
        .DECODE_WIDTH (W)
    ) dut (
        .clk_in       (clk_in),
        .rst          (rst),
        .flush        (flush),
        .fetch        (fetch),
        .fetch_valid  (fetch_valid),
        .decode_ready (decode_ready),
        .out          (out),
        .out_valid    (out_valid),
        .exe_ready    (exe_ready)
    );

    // ############################################################
    // Reference model
    // ############################################################

    function automatic uop_group_t expected_group(input fetch_group_t f);
        uop_group_t g;
        uop_t       u;
        insn_t      w;
        logic       known;
        logic       stopped;
        int         k;
        g       = '0;
        stopped = 1'b0;
        k       = 0;
        for (int i = 0; i < W; i++) begin
            w     = f.insn[i];
            u     = '0;
            u.pc  = f.pc + 64'(4 * i);
            known = 1'b1;
            if (w[31:21] == ADDS_REG || w[31:22] == ADD_IMM)      u.code = UOP_ADD;
            else if (w[31:21] == SUBS_REG || w[31:22] == SUB_IMM) u.code = UOP_SUB;
            else if (w[31:21] == ORR_REG)                         u.code = UOP_ORR;
            else if (w[31:21] == EOR_REG)                         u.code = UOP_EOR;
            else if (w[31:21] == ANDS_REG)                        u.code = UOP_AND;
            else if (w[31:23] == MOVZ)                            u.code = UOP_MOVZ;
            else if (w[31:23] == MOVK)                            u.code = UOP_MOVK;
            else if (w[31:21] == HLT)                             u.code = UOP_HLT;
            else if (w[31:24] == BCOND)                           u.code = UOP_BCOND;
            else                                                  known = 1'b0;  // B, NOP, junk
            if (w[31:21] inside {ADDS_REG, SUBS_REG, ORR_REG, EOR_REG, ANDS_REG}) begin
                u.use_rr          = 1'b1;
                u.ops.rr.dst.gpr  = w[4:0];
                u.ops.rr.src1.gpr = w[9:5];
                u.ops.rr.src2.gpr = w[20:16];
            end else if (w[31:22] == ADD_IMM || w[31:22] == SUB_IMM) begin
                u.ops.ri.dst.gpr   = w[4:0];
                u.ops.ri.dst.is_sp = (w[9:5] == 5'd31) && (w[4:0] == 5'd31);
                u.ops.ri.src.gpr   = w[9:5];
                u.ops.ri.src.is_sp = (w[9:5] == 5'd31);
                u.ops.ri.imm       = {4'b0000, w[21:10]};
            end else if (u.code inside {UOP_MOVZ, UOP_MOVK}) begin
                u.ops.ri.dst.gpr = w[4:0];
                u.ops.ri.imm     = w[20:5];
                u.ops.ri.hw      = w[22:21];
            end
            if (known && !stopped) begin
                g.valid[k] = 1'b1;
                g.slot[k]  = u;
                k++;
            end
            stopped = stopped || w[31:26] == B || (u.code == UOP_BCOND && f.taken[i]);
        end
        return g;
    endfunction

    function automatic insn_t random_insn();
        logic [31:0] r;
        r = $urandom;
        case ($urandom % 10)
            0:       return {ADDS_REG, r[20:16], 6'd0, r[9:0]};
            1:       return {SUBS_REG, r[20:16], 6'd0, r[9:0]};
            2:       return {ORR_REG, r[20:16], 6'd0, r[9:0]};
            3:       return {EOR_REG, r[20:16], 6'd0, r[9:0]};
            4:       return {ANDS_REG, r[20:16], 6'd0, r[9:0]};
            5:       return {r[31] ? SUB_IMM : ADD_IMM, r[21:0]};
            6:       return {r[31] ? MOVK : MOVZ, r[22:0]};
            7:       return r[31] ? {HLT, r[20:5], 5'd0} : {BCOND, r[23:5], 1'b0, r[3:0]};
            8:       return r[31] ? {B, r[25:0]} : NOP_WORD;
            default: return r;  // Mostly unknown encodings
        endcase
    endfunction

    function automatic fetch_group_t random_fetch();
        fetch_group_t f;
        logic [63:0]  p;
        p = {$urandom, $urandom};
        for (int i = 0; i < W; i++) begin
            f.insn[i] = random_insn();
        end
        f.pc    = {p[63:2], 2'b00};
        f.taken = W'($urandom);
        return f;
    endfunction

    function automatic fetch_group_t lanes(input insn_t w0, input insn_t w1,
                                           input logic [W-1:0] taken, input logic [63:0] pc);
        fetch_group_t f;
        f.insn[0] = w0;
        f.insn[1] = w1;
        f.taken   = taken;
        f.pc      = pc;
        return f;
    endfunction

    // ############################################################
    // Drivers and checks
    // ############################################################

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic tick();
        @(negedge clk_in);
        exe_ready = rand_ready ? (($urandom % 3) != 0) : 1'b1;
    endtask

    task automatic idle();
        tick();
        fetch_valid = 1'b0;
        fetch       = random_fetch();  // Junk that must be ignored
    endtask

    // decode_ready only moves on rising edges, so its value here decides the next edge
    task automatic send_group(input fetch_group_t f);
        int waited;
        waited = 0;
        tick();
        fetch       = f;
        fetch_valid = 1'b1;
        while (!decode_ready && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (!decode_ready) begin
            timeouts++;
            $display("Timeout at %0t: decode never accepted a fetch group", $time);
        end
    endtask

    task automatic flush_pipe();
        tick();
        exe_ready   = 1'b0;
        fetch_valid = 1'b1;
        fetch       = random_fetch();
        flush       = 1'b1;
        tick();
        flush       = 1'b0;
        fetch_valid = 1'b0;
        check_value("out_valid", 256'(out_valid), 256'(0));
        check_value("decode_ready", 256'(decode_ready), 256'(0));
    endtask

    always @(posedge clk_in) begin
        uop_group_t exp_g;
        if (rst || flush) begin
            expect_q.delete();
            prev_stall <= 1'b0;
        end else begin
            if (prev_stall) begin
                check_value("out_valid", 256'(out_valid), 256'(1));
                check_value("out", 256'(out), 256'(prev_out));
            end
            if (out_valid && exe_ready) begin
                if (expect_q.size() == 0) begin
                    errors++;
                    $display("Output group at %0t arrived with nothing expected", $time);
                end else begin
                    exp_g = expect_q.pop_front();
                    check_value("out.valid", 256'(out.valid), 256'(exp_g.valid));
                    for (int s = 0; s < W; s++) begin
                        check_value($sformatf("out.slot[%0d]", s), 256'(out.slot[s]),
                                    256'(exp_g.slot[s]));
                    end
                end
            end
            if (fetch_valid && decode_ready) begin
                exp_g = expected_group(fetch);
                if (exp_g.valid != '0) begin
                    expect_q.push_back(exp_g);
                end
            end
            prev_stall <= out_valid && !exe_ready;
        end
        prev_out <= out;
    end

    // ############################################################
    // Test sequence
    // ############################################################

    initial begin
        insn_t b_w;
        insn_t bc_w;
        insn_t hlt_w;
        insn_t add_w;
        int    waited;
        void'($urandom(32'hfc69));
        b_w   = {B, 26'h0000010};
        bc_w  = {BCOND, 19'h00004, 1'b0, 4'h1};
        hlt_w = {HLT, 16'h0000, 5'd0};
        add_w = {ADDS_REG, 5'd5, 6'd0, 5'd4, 5'd3};
        repeat (2) tick();
        rst = 1'b0;

        send_group(lanes(add_w, {EOR_REG, 5'd29, 6'd0, 5'd30, 5'd31}, 2'b00, 64'h40_0000));
        send_group(lanes({ORR_REG, 5'd3, 6'd0, 5'd2, 5'd1}, {ANDS_REG, 5'd8, 6'd0, 5'd31, 5'd7},
                         2'b11, 64'hffff_ffff_ffff_fffc));
        send_group(lanes({SUBS_REG, 5'd12, 6'd0, 5'd11, 5'd10}, {ADD_IMM, 12'hfff, 5'd31, 5'd31},
                         2'b00, 64'h1000));
        send_group(lanes({SUB_IMM, 12'h010, 5'd31, 5'd2}, {ADD_IMM, 12'h001, 5'd7, 5'd31},
                         2'b00, 64'h2000));
        send_group(lanes({MOVZ, 2'd3, 16'hbeef, 5'd9}, {MOVK, 2'd1, 16'h1234, 5'd31},
                         2'b00, 64'h3000));
        send_group(lanes(b_w, add_w, 2'b00, 64'h4000));         // B drops lane 1
        send_group(lanes(bc_w, add_w, 2'b01, 64'h5000));        // Taken B.cond ends the group
        send_group(lanes(bc_w, add_w, 2'b00, 64'h6000));
        send_group(lanes(NOP_WORD, hlt_w, 2'b00, 64'h7000));
        send_group(lanes(32'h0000_0000, add_w, 2'b00, 64'h8000));
        send_group(lanes(NOP_WORD, NOP_WORD, 2'b00, 64'h9000));  // No output at all
        send_group(lanes(add_w, b_w, 2'b00, 64'ha000));
        send_group(lanes(add_w, bc_w, 2'b10, 64'hb000));

        rand_ready = 1'b1;
        for (int n = 0; n < 400; n++) begin
            if (n == 200) begin
                flush_pipe();
            end
            if ($urandom % 4 == 0) begin
                idle();
            end
            send_group(random_fetch());
        end
        rand_ready = 1'b0;
        idle();
        waited = 0;
        while (expect_q.size() != 0 && waited < TIMEOUT) begin
            idle();
            waited++;
        end
        repeat (3) idle();

        if (expect_q.size() != 0) begin
            $display("%0d expected groups never came out of decode", expect_q.size());
        end
        $display("checks=%0d errors=%0d timeouts=%0d pending=%0d",
                 checks, errors, timeouts, expect_q.size());
        if (errors == 0 && timeouts == 0 && expect_q.size() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
isa_pkg.sv
uop_pkg.sv
insn_decoder.sv
group_packer.sv
decode_skid.sv
decode_top.sv
decode_chk.sv
decode_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f sim.f --top-module decode_tb -o decode_sim \
    && ./obj_dir/decode_sim | tee /dev/stderr | grep -qx '>>> PASS' \
    && echo "decode simulation passed" \
    || { echo "decode simulation failed"; exit 1; }
